/* verilog/dec_cfg.svh */
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// instruction word width, also the immediate width
`define DEC_INST_W 32

// register index width
`define DEC_REG_W 5

// stages from inst_i to the registered outputs
`define DEC_DEPTH 3

`endif

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // base major opcodes, bits 6:0
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        MAJ_LOAD,
        MAJ_STORE,
        MAJ_OP_IMM,
        MAJ_OP,
        MAJ_LUI,
        MAJ_AUIPC,
        MAJ_BRANCH,
        MAJ_JAL,
        MAJ_JALR,
        MAJ_OTHER
    } major_e;

    typedef enum logic [5:0] {
        OP_ILLEGAL,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } op_e;

    typedef enum logic [2:0] {
        CLS_UPPER,
        CLS_JUMP,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_IMM,
        CLS_REG,
        CLS_NONE
    } class_e;

endpackage

`default_nettype wire

/* verilog/dec_pipe_pkg.sv */
`default_nettype none

`include "dec_cfg.svh"

package dec_pipe_pkg;

    // instruction fields in word order, msb first
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`DEC_REG_W-1:0] rs2;
        logic [`DEC_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`DEC_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } fields_t;

endpackage

`default_nettype wire

/* verilog/dec_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

// stage 1 to stage 2
interface dec_fields_if;
    logic                    valid;
    logic [`DEC_INST_W-1:0]  inst;
    dec_pipe_pkg::fields_t   fields;

    modport src (output valid, inst, fields);
    modport dst (input  valid, inst, fields);
endinterface

// stage 2 to stage 3
interface dec_predec_if;
    logic                    valid;
    logic [`DEC_INST_W-1:0]  inst;
    rv_isa_pkg::major_e      major;
    logic [2:0]              funct3;
    logic                    f7_zero;
    logic                    f7_alt;
    logic [`DEC_REG_W-1:0]   rs1;
    logic [`DEC_REG_W-1:0]   rs2;
    logic [`DEC_REG_W-1:0]   rd;
    logic [`DEC_INST_W-1:0]  imm;

    modport src (output valid, inst, major, funct3, f7_zero, f7_alt,
                 rs1, rs2, rd, imm);
    modport dst (input  valid, inst, major, funct3, f7_zero, f7_alt,
                 rs1, rs2, rd, imm);
endinterface

`default_nettype wire

/* verilog/dec_imm_extract.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

module dec_imm_extract (
    input  wire [`DEC_INST_W-1:0]  inst_i,
    input  wire rv_isa_pkg::major_e major_i,
    output logic [`DEC_INST_W-1:0] imm_o
);

    always_comb begin
        case (major_i)
            // I format, shifts keep funct7 in the upper bits
            rv_isa_pkg::MAJ_LOAD,
            rv_isa_pkg::MAJ_JALR,
            rv_isa_pkg::MAJ_OP_IMM:
                imm_o = {{(`DEC_INST_W-12){inst_i[31]}}, inst_i[31:20]};
            rv_isa_pkg::MAJ_STORE:
                imm_o = {{(`DEC_INST_W-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            rv_isa_pkg::MAJ_BRANCH:
                imm_o = {{(`DEC_INST_W-13){inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            rv_isa_pkg::MAJ_LUI,
            rv_isa_pkg::MAJ_AUIPC:
                imm_o = {inst_i[31:12], 12'b0};
            rv_isa_pkg::MAJ_JAL:
                imm_o = {{(`DEC_INST_W-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            // register ops and anything unmatched
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dec_field_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

module dec_field_capture (
    input  wire                    hclk,
    input  wire                    hrstn,
    input  wire                    stall_i,
    input  wire                    inst_valid_i,
    input  wire [`DEC_INST_W-1:0]  inst_i,
    dec_fields_if.src              fld_o
);

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            fld_o.valid <= 1'b0;
        end else if (!stall_i) begin
            fld_o.valid <= inst_valid_i;
        end
    end

    // word and its slices, loaded only on accept
    always_ff @(posedge hclk) begin
        if (!stall_i && inst_valid_i) begin
            fld_o.inst          <= inst_i;
            fld_o.fields.funct7 <= inst_i[31:25];
            fld_o.fields.rs2    <= inst_i[24:20];
            fld_o.fields.rs1    <= inst_i[19:15];
            fld_o.fields.funct3 <= inst_i[14:12];
            fld_o.fields.rd     <= inst_i[11:7];
            fld_o.fields.opcode <= inst_i[6:0];
        end
    end

    // stage 1 frozen on a stalled edge
    a_hold_on_stall: assert property (
        @(posedge hclk) disable iff (!hrstn)
        stall_i |=> $stable(fld_o.valid) && (!fld_o.valid || $stable(fld_o.fields))
    );

endmodule

`default_nettype wire

/* verilog/dec_major_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

module dec_major_decode (
    input  wire         hclk,
    input  wire         hrstn,
    input  wire         stall_i,
    dec_fields_if.dst   fld_i,
    dec_predec_if.src   pre_o
);

    rv_isa_pkg::major_e      major;
    logic                    f7_zero;
    logic                    f7_alt;
    logic [`DEC_INST_W-1:0]  imm;

    always_comb begin
        case (fld_i.fields.opcode)
            rv_isa_pkg::OPC_LOAD:   major = rv_isa_pkg::MAJ_LOAD;
            rv_isa_pkg::OPC_STORE:  major = rv_isa_pkg::MAJ_STORE;
            rv_isa_pkg::OPC_OP_IMM: major = rv_isa_pkg::MAJ_OP_IMM;
            rv_isa_pkg::OPC_OP:     major = rv_isa_pkg::MAJ_OP;
            rv_isa_pkg::OPC_LUI:    major = rv_isa_pkg::MAJ_LUI;
            rv_isa_pkg::OPC_AUIPC:  major = rv_isa_pkg::MAJ_AUIPC;
            rv_isa_pkg::OPC_BRANCH: major = rv_isa_pkg::MAJ_BRANCH;
            rv_isa_pkg::OPC_JAL:    major = rv_isa_pkg::MAJ_JAL;
            rv_isa_pkg::OPC_JALR:   major = rv_isa_pkg::MAJ_JALR;
            // system, fence and unknown opcodes
            default:                major = rv_isa_pkg::MAJ_OTHER;
        endcase
    end

    // the only two funct7 patterns stage 3 accepts
    assign f7_zero = (fld_i.fields.funct7 == 7'b0000000);
    assign f7_alt  = (fld_i.fields.funct7 == 7'b0100000);

    dec_imm_extract i_imm_extract (
        .inst_i  (fld_i.inst),
        .major_i (major),
        .imm_o   (imm)
    );

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            pre_o.valid <= 1'b0;
        end else if (!stall_i) begin
            pre_o.valid <= fld_i.valid;
        end
    end

    always_ff @(posedge hclk) begin
        if (!stall_i && fld_i.valid) begin
            pre_o.inst    <= fld_i.inst;
            pre_o.major   <= major;
            pre_o.funct3  <= fld_i.fields.funct3;
            pre_o.f7_zero <= f7_zero;
            pre_o.f7_alt  <= f7_alt;
            pre_o.rs1     <= fld_i.fields.rs1;
            pre_o.rs2     <= fld_i.fields.rs2;
            pre_o.rd      <= fld_i.fields.rd;
            pre_o.imm     <= imm;
        end
    end

endmodule

`default_nettype wire

/* verilog/dec_op_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

module dec_op_select (
    input  wire                      hclk,
    input  wire                      hrstn,
    input  wire                      stall_i,
    dec_predec_if.dst                pre_i,
    output logic                     out_valid_o,
    output logic [`DEC_INST_W-1:0]   out_inst_o,
    output rv_isa_pkg::op_e          op_o,
    output rv_isa_pkg::class_e       class_o,
    output logic [`DEC_REG_W-1:0]    rs1_o,
    output logic [`DEC_REG_W-1:0]    rs2_o,
    output logic [`DEC_REG_W-1:0]    rd_o,
    output logic [`DEC_INST_W-1:0]   imm_o
);

    rv_isa_pkg::op_e     op;
    rv_isa_pkg::class_e  cls;

    always_comb begin
        op = rv_isa_pkg::OP_ILLEGAL;
        case (pre_i.major)
            rv_isa_pkg::MAJ_LUI:   op = rv_isa_pkg::OP_LUI;
            rv_isa_pkg::MAJ_AUIPC: op = rv_isa_pkg::OP_AUIPC;
            rv_isa_pkg::MAJ_JAL:   op = rv_isa_pkg::OP_JAL;
            rv_isa_pkg::MAJ_JALR: begin
                if (pre_i.funct3 == 3'b000) begin
                    op = rv_isa_pkg::OP_JALR;
                end
            end
            rv_isa_pkg::MAJ_BRANCH: begin
                case (pre_i.funct3)
                    3'b000:  op = rv_isa_pkg::OP_BEQ;
                    3'b001:  op = rv_isa_pkg::OP_BNE;
                    3'b100:  op = rv_isa_pkg::OP_BLT;
                    3'b101:  op = rv_isa_pkg::OP_BGE;
                    3'b110:  op = rv_isa_pkg::OP_BLTU;
                    3'b111:  op = rv_isa_pkg::OP_BGEU;
                    default: op = rv_isa_pkg::OP_ILLEGAL;
                endcase
            end
            rv_isa_pkg::MAJ_LOAD: begin
                case (pre_i.funct3)
                    3'b000:  op = rv_isa_pkg::OP_LB;
                    3'b001:  op = rv_isa_pkg::OP_LH;
                    3'b010:  op = rv_isa_pkg::OP_LW;
                    3'b100:  op = rv_isa_pkg::OP_LBU;
                    3'b101:  op = rv_isa_pkg::OP_LHU;
                    default: op = rv_isa_pkg::OP_ILLEGAL;
                endcase
            end
            rv_isa_pkg::MAJ_STORE: begin
                case (pre_i.funct3)
                    3'b000:  op = rv_isa_pkg::OP_SB;
                    3'b001:  op = rv_isa_pkg::OP_SH;
                    3'b010:  op = rv_isa_pkg::OP_SW;
                    default: op = rv_isa_pkg::OP_ILLEGAL;
                endcase
            end
            rv_isa_pkg::MAJ_OP_IMM: begin
                case (pre_i.funct3)
                    3'b000: op = rv_isa_pkg::OP_ADDI;
                    3'b010: op = rv_isa_pkg::OP_SLTI;
                    3'b011: op = rv_isa_pkg::OP_SLTIU;
                    3'b100: op = rv_isa_pkg::OP_XORI;
                    3'b110: op = rv_isa_pkg::OP_ORI;
                    3'b111: op = rv_isa_pkg::OP_ANDI;
                    // shifts also check the funct7 part of the immediate
                    3'b001: begin
                        if (pre_i.f7_zero) begin
                            op = rv_isa_pkg::OP_SLLI;
                        end
                    end
                    default: begin
                        if (pre_i.f7_zero) begin
                            op = rv_isa_pkg::OP_SRLI;
                        end else if (pre_i.f7_alt) begin
                            op = rv_isa_pkg::OP_SRAI;
                        end
                    end
                endcase
            end
            rv_isa_pkg::MAJ_OP: begin
                if (pre_i.f7_zero) begin
                    case (pre_i.funct3)
                        3'b000:  op = rv_isa_pkg::OP_ADD;
                        3'b001:  op = rv_isa_pkg::OP_SLL;
                        3'b010:  op = rv_isa_pkg::OP_SLT;
                        3'b011:  op = rv_isa_pkg::OP_SLTU;
                        3'b100:  op = rv_isa_pkg::OP_XOR;
                        3'b101:  op = rv_isa_pkg::OP_SRL;
                        3'b110:  op = rv_isa_pkg::OP_OR;
                        default: op = rv_isa_pkg::OP_AND;
                    endcase
                end else if (pre_i.f7_alt) begin
                    // only sub and sra use the alternate encoding
                    if (pre_i.funct3 == 3'b000) begin
                        op = rv_isa_pkg::OP_SUB;
                    end else if (pre_i.funct3 == 3'b101) begin
                        op = rv_isa_pkg::OP_SRA;
                    end
                end
            end
            default: op = rv_isa_pkg::OP_ILLEGAL;
        endcase
    end

    always_comb begin
        case (op)
            rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC:
                cls = rv_isa_pkg::CLS_UPPER;
            rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR:
                cls = rv_isa_pkg::CLS_JUMP;
            rv_isa_pkg::OP_BEQ, rv_isa_pkg::OP_BNE, rv_isa_pkg::OP_BLT,
            rv_isa_pkg::OP_BGE, rv_isa_pkg::OP_BLTU, rv_isa_pkg::OP_BGEU:
                cls = rv_isa_pkg::CLS_BRANCH;
            rv_isa_pkg::OP_LB, rv_isa_pkg::OP_LH, rv_isa_pkg::OP_LW,
            rv_isa_pkg::OP_LBU, rv_isa_pkg::OP_LHU:
                cls = rv_isa_pkg::CLS_LOAD;
            rv_isa_pkg::OP_SB, rv_isa_pkg::OP_SH, rv_isa_pkg::OP_SW:
                cls = rv_isa_pkg::CLS_STORE;
            rv_isa_pkg::OP_ADDI, rv_isa_pkg::OP_SLTI, rv_isa_pkg::OP_SLTIU,
            rv_isa_pkg::OP_XORI, rv_isa_pkg::OP_ORI, rv_isa_pkg::OP_ANDI,
            rv_isa_pkg::OP_SLLI, rv_isa_pkg::OP_SRLI, rv_isa_pkg::OP_SRAI:
                cls = rv_isa_pkg::CLS_IMM;
            rv_isa_pkg::OP_ILLEGAL:
                cls = rv_isa_pkg::CLS_NONE;
            default:
                cls = rv_isa_pkg::CLS_REG;
        endcase
    end

    always_ff @(posedge hclk or negedge hrstn) begin
        if (!hrstn) begin
            out_valid_o <= 1'b0;
            op_o        <= rv_isa_pkg::OP_ILLEGAL;
            class_o     <= rv_isa_pkg::CLS_NONE;
        end else if (!stall_i) begin
            out_valid_o <= pre_i.valid;
            if (pre_i.valid) begin
                op_o    <= op;
                class_o <= cls;
            end
        end
    end

    // payload outputs hold between instructions
    always_ff @(posedge hclk) begin
        if (!stall_i && pre_i.valid) begin
            out_inst_o <= pre_i.inst;
            rs1_o      <= pre_i.rs1;
            rs2_o      <= pre_i.rs2;
            rd_o       <= pre_i.rd;
            imm_o      <= pre_i.imm;
        end
    end

    a_class_matches_op: assert property (
        @(posedge hclk) disable iff (!hrstn)
        out_valid_o |-> ((class_o == rv_isa_pkg::CLS_NONE) == (op_o == rv_isa_pkg::OP_ILLEGAL))
    );

endmodule

`default_nettype wire

/* verilog/dec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

module dec_top (
    input  wire                      hclk,
    input  wire                      hrstn,
    input  wire                      stall_i,
    input  wire                      inst_valid_i,
    input  wire [`DEC_INST_W-1:0]    inst_i,
    output logic                     out_valid_o,
    output logic [`DEC_INST_W-1:0]   out_inst_o,
    output rv_isa_pkg::op_e          op_o,
    output rv_isa_pkg::class_e       class_o,
    output logic [`DEC_REG_W-1:0]    rs1_o,
    output logic [`DEC_REG_W-1:0]    rs2_o,
    output logic [`DEC_REG_W-1:0]    rd_o,
    output logic [`DEC_INST_W-1:0]   imm_o
);

    dec_fields_if i_fields_if ();
    dec_predec_if i_predec_if ();

    // stage 1
    dec_field_capture i_field_capture (
        .hclk         (hclk),
        .hrstn        (hrstn),
        .stall_i      (stall_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .fld_o        (i_fields_if.src)
    );

    // stage 2
    dec_major_decode i_major_decode (
        .hclk    (hclk),
        .hrstn   (hrstn),
        .stall_i (stall_i),
        .fld_i   (i_fields_if.dst),
        .pre_o   (i_predec_if.src)
    );

    // stage 3
    dec_op_select i_op_select (
        .hclk        (hclk),
        .hrstn       (hrstn),
        .stall_i     (stall_i),
        .pre_i       (i_predec_if.dst),
        .out_valid_o (out_valid_o),
        .out_inst_o  (out_inst_o),
        .op_o        (op_o),
        .class_o     (class_o),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o),
        .rd_o        (rd_o),
        .imm_o       (imm_o)
    );

endmodule

`default_nettype wire

/* test/tb_dec_model.svh */
`ifndef TB_DEC_MODEL_SVH
`define TB_DEC_MODEL_SVH

`include "dec_cfg.svh"

// one expected result, due is the unstalled edge it must appear on
typedef struct packed {
    logic [`DEC_INST_W-1:0] inst;
    rv_isa_pkg::op_e        op;
    rv_isa_pkg::class_e     cls;
    logic [`DEC_REG_W-1:0]  rs1;
    logic [`DEC_REG_W-1:0]  rs2;
    logic [`DEC_REG_W-1:0]  rd;
    logic [`DEC_INST_W-1:0] imm;
    logic [31:0]            due;
} expect_t;

localparam logic [31:0] LFSR_SEED = 32'h2023_d0f7;

logic [31:0] lfsr_state;

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic rv_isa_pkg::op_e model_op(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
        7'b0110111: return rv_isa_pkg::OP_LUI;
        7'b0010111: return rv_isa_pkg::OP_AUIPC;
        7'b1101111: return rv_isa_pkg::OP_JAL;
        7'b1100111: return (f3 == 3'd0) ? rv_isa_pkg::OP_JALR : rv_isa_pkg::OP_ILLEGAL;
        7'b1100011: begin
            case (f3)
                3'd0:    return rv_isa_pkg::OP_BEQ;
                3'd1:    return rv_isa_pkg::OP_BNE;
                3'd4:    return rv_isa_pkg::OP_BLT;
                3'd5:    return rv_isa_pkg::OP_BGE;
                3'd6:    return rv_isa_pkg::OP_BLTU;
                3'd7:    return rv_isa_pkg::OP_BGEU;
                default: return rv_isa_pkg::OP_ILLEGAL;
            endcase
        end
        7'b0000011: begin
            case (f3)
                3'd0:    return rv_isa_pkg::OP_LB;
                3'd1:    return rv_isa_pkg::OP_LH;
                3'd2:    return rv_isa_pkg::OP_LW;
                3'd4:    return rv_isa_pkg::OP_LBU;
                3'd5:    return rv_isa_pkg::OP_LHU;
                default: return rv_isa_pkg::OP_ILLEGAL;
            endcase
        end
        7'b0100011: begin
            case (f3)
                3'd0:    return rv_isa_pkg::OP_SB;
                3'd1:    return rv_isa_pkg::OP_SH;
                3'd2:    return rv_isa_pkg::OP_SW;
                default: return rv_isa_pkg::OP_ILLEGAL;
            endcase
        end
        7'b0010011: begin
            case (f3)
                3'd0: return rv_isa_pkg::OP_ADDI;
                3'd2: return rv_isa_pkg::OP_SLTI;
                3'd3: return rv_isa_pkg::OP_SLTIU;
                3'd4: return rv_isa_pkg::OP_XORI;
                3'd6: return rv_isa_pkg::OP_ORI;
                3'd7: return rv_isa_pkg::OP_ANDI;
                3'd1: return (f7 == 7'h00) ? rv_isa_pkg::OP_SLLI : rv_isa_pkg::OP_ILLEGAL;
                default: begin
                    if (f7 == 7'h00) begin
                        return rv_isa_pkg::OP_SRLI;
                    end
                    return (f7 == 7'h20) ? rv_isa_pkg::OP_SRAI : rv_isa_pkg::OP_ILLEGAL;
                end
            endcase
        end
        7'b0110011: begin
            case ({f7, f3})
                {7'h00, 3'd0}: return rv_isa_pkg::OP_ADD;
                {7'h20, 3'd0}: return rv_isa_pkg::OP_SUB;
                {7'h00, 3'd1}: return rv_isa_pkg::OP_SLL;
                {7'h00, 3'd2}: return rv_isa_pkg::OP_SLT;
                {7'h00, 3'd3}: return rv_isa_pkg::OP_SLTU;
                {7'h00, 3'd4}: return rv_isa_pkg::OP_XOR;
                {7'h00, 3'd5}: return rv_isa_pkg::OP_SRL;
                {7'h20, 3'd5}: return rv_isa_pkg::OP_SRA;
                {7'h00, 3'd6}: return rv_isa_pkg::OP_OR;
                {7'h00, 3'd7}: return rv_isa_pkg::OP_AND;
                default:       return rv_isa_pkg::OP_ILLEGAL;
            endcase
        end
        default: return rv_isa_pkg::OP_ILLEGAL;
    endcase
endfunction

// class follows the opcode unless the operation is illegal
function automatic rv_isa_pkg::class_e model_class(input logic [31:0] w,
                                                   input rv_isa_pkg::op_e op);
    if (op == rv_isa_pkg::OP_ILLEGAL) begin
        return rv_isa_pkg::CLS_NONE;
    end
    case (w[6:0])
        7'b0110111, 7'b0010111: return rv_isa_pkg::CLS_UPPER;
        7'b1101111, 7'b1100111: return rv_isa_pkg::CLS_JUMP;
        7'b1100011:             return rv_isa_pkg::CLS_BRANCH;
        7'b0000011:             return rv_isa_pkg::CLS_LOAD;
        7'b0100011:             return rv_isa_pkg::CLS_STORE;
        7'b0010011:             return rv_isa_pkg::CLS_IMM;
        default:                return rv_isa_pkg::CLS_REG;
    endcase
endfunction

function automatic logic [31:0] model_imm(input logic [31:0] w);
    case (w[6:0])
        7'b0000011, 7'b1100111, 7'b0010011:
            return {{20{w[31]}}, w[31:20]};
        7'b0100011:
            return {{20{w[31]}}, w[31:25], w[11:7]};
        7'b1100011:
            return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        7'b0110111, 7'b0010111:
            return {w[31:12], 12'h000};
        7'b1101111:
            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default:
            return 32'h0;
    endcase
endfunction

function automatic expect_t predict(input logic [31:0] w, input logic [31:0] due);
    expect_t e;
    e.inst = w;
    e.op   = model_op(w);
    e.cls  = model_class(w, e.op);
    e.rs1  = w[19:15];
    e.rs2  = w[24:20];
    e.rd   = w[11:7];
    e.imm  = model_imm(w);
    e.due  = due;
    return e;
endfunction

task automatic check_op(input string name, input rv_isa_pkg::op_e got,
                        input rv_isa_pkg::op_e exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        stop_run();
    end
endtask

task automatic check_class(input string name, input rv_isa_pkg::class_e got,
                           input rv_isa_pkg::class_e exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        stop_run();
    end
endtask

task automatic check_reg(input string name, input logic [`DEC_REG_W-1:0] got,
                         input logic [`DEC_REG_W-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_word(input string name, input logic [`DEC_INST_W-1:0] got,
                          input logic [`DEC_INST_W-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

`endif

/* test/tb_dec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dec_cfg.svh"

module tb_dec_top;

    localparam int CLK_NS      = 4;
    localparam int NUM_B2B     = 64;
    localparam int NUM_TESTS   = 2000;
    localparam int WATCHDOG_NS = (NUM_B2B + NUM_TESTS + `DEC_DEPTH + 20) * CLK_NS * 4;

    logic                   hclk;
    logic                   hrstn;
    logic                   stall_i;
    logic                   inst_valid_i;
    logic [`DEC_INST_W-1:0] inst_i;
    logic                   out_valid_o;
    logic [`DEC_INST_W-1:0] out_inst_o;
    rv_isa_pkg::op_e        op_o;
    rv_isa_pkg::class_e     class_o;
    logic [`DEC_REG_W-1:0]  rs1_o;
    logic [`DEC_REG_W-1:0]  rs2_o;
    logic [`DEC_REG_W-1:0]  rd_o;
    logic [`DEC_INST_W-1:0] imm_o;

    `include "tb_dec_model.svh"

    expect_t exp_q[$];
    expect_t snap;
    logic    snap_valid = 1'b0;
    logic    edge_stalled = 1'b0;
    int      edge_count = 0;
    int      accepted = 0;
    int      checked = 0;

    dec_top i_dut (
        .hclk         (hclk),
        .hrstn        (hrstn),
        .stall_i      (stall_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .out_valid_o  (out_valid_o),
        .out_inst_o   (out_inst_o),
        .op_o         (op_o),
        .class_o      (class_o),
        .rs1_o        (rs1_o),
        .rs2_o        (rs2_o),
        .rd_o         (rd_o),
        .imm_o        (imm_o)
    );

    always #(CLK_NS / 2) hclk = ~hclk;

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // half kept opcodes with biased funct7, half raw words
    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        logic [31:0] sel;
        w = rand_bits(32);
        if (rand_bits(1) == 32'd1) begin
            sel = rand_bits(4) % 9;
            if (sel == 0) w[6:0] = rv_isa_pkg::OPC_LOAD;
            else if (sel == 1) w[6:0] = rv_isa_pkg::OPC_STORE;
            else if (sel == 2) w[6:0] = rv_isa_pkg::OPC_OP_IMM;
            else if (sel == 3) w[6:0] = rv_isa_pkg::OPC_OP;
            else if (sel == 4) w[6:0] = rv_isa_pkg::OPC_LUI;
            else if (sel == 5) w[6:0] = rv_isa_pkg::OPC_AUIPC;
            else if (sel == 6) w[6:0] = rv_isa_pkg::OPC_BRANCH;
            else if (sel == 7) w[6:0] = rv_isa_pkg::OPC_JAL;
            else w[6:0] = rv_isa_pkg::OPC_JALR;
            sel = rand_bits(2);
            if (sel == 0) begin
                w[31:25] = 7'b0000000;
            end else if (sel == 1) begin
                w[31:25] = 7'b0100000;
            end
        end
        return w;
    endfunction

    // accept tracking, inputs are stable at the rising edge
    always @(posedge hclk) begin
        if (hrstn) begin
            edge_stalled = stall_i;
            if (!stall_i) begin
                edge_count = edge_count + 1;
                if (inst_valid_i) begin
                    // three registers, the first one loads on the accept edge
                    exp_q.push_back(predict(inst_i, edge_count + `DEC_DEPTH - 1));
                    accepted++;
                end
            end
        end
    end

    // outputs checked half a cycle after the edge that moved them
    always @(negedge hclk) begin
        expect_t head;
        if (hrstn) begin
            if (edge_stalled) begin
                check_word("out_valid_o", {31'b0, out_valid_o}, {31'b0, snap_valid});
                check_word("out_inst_o", out_inst_o, snap.inst);
                check_op("op_o", op_o, snap.op);
                check_class("class_o", class_o, snap.cls);
                check_reg("rs1_o", rs1_o, snap.rs1);
                check_reg("rs2_o", rs2_o, snap.rs2);
                check_reg("rd_o", rd_o, snap.rd);
                check_word("imm_o", imm_o, snap.imm);
            end else if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid_o went high with no instruction in flight");
                    stop_run();
                end else begin
                    head = exp_q.pop_front();
                    check_word("out_valid_o edge", edge_count, head.due);
                    check_word("out_inst_o", out_inst_o, head.inst);
                    check_op("op_o", op_o, head.op);
                    check_class("class_o", class_o, head.cls);
                    check_reg("rs1_o", rs1_o, head.rs1);
                    check_reg("rs2_o", rs2_o, head.rs2);
                    check_reg("rd_o", rd_o, head.rd);
                    check_word("imm_o", imm_o, head.imm);
                    checked++;
                end
            end else if (exp_q.size() != 0 && exp_q[0].due == edge_count) begin
                $display("a result was due but out_valid_o stayed low");
                stop_run();
            end
            snap_valid = out_valid_o;
            snap.inst  = out_inst_o;
            snap.op    = op_o;
            snap.cls   = class_o;
            snap.rs1   = rs1_o;
            snap.rs2   = rs2_o;
            snap.rd    = rd_o;
            snap.imm   = imm_o;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the decoder did not deliver all results in time");
        stop_run();
    end

    initial begin
        int i;
        hclk         = 1'b0;
        hrstn        = 1'b0;
        stall_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        lfsr_state   = LFSR_SEED;
        repeat (10) @(posedge hclk);
        #1 hrstn = 1'b1;

        // reset values before the first instruction
        @(negedge hclk);
        check_word("out_valid_o", {31'b0, out_valid_o}, 32'h0);
        check_op("op_o", op_o, rv_isa_pkg::OP_ILLEGAL);
        check_class("class_o", class_o, rv_isa_pkg::CLS_NONE);

        // back to back, no stall
        for (i = 0; i < NUM_B2B; i++) begin
            @(posedge hclk);
            #1;
            stall_i      = 1'b0;
            inst_valid_i = 1'b1;
            inst_i       = make_inst();
        end

        // random valid and stall, nothing new offered under stall
        for (i = 0; i < NUM_TESTS; i++) begin
            @(posedge hclk);
            #1;
            stall_i = (rand_bits(2) == 32'd0);
            if (stall_i) begin
                inst_valid_i = 1'b0;
            end else begin
                inst_valid_i = (rand_bits(2) != 32'd0);
            end
            if (inst_valid_i) begin
                inst_i = make_inst();
            end
        end

        @(posedge hclk);
        #1;
        stall_i      = 1'b0;
        inst_valid_i = 1'b0;
        while (checked != accepted) @(negedge hclk);
        repeat (2 * `DEC_DEPTH) @(negedge hclk);

        if (checked == accepted && exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d results checked of %0d accepted", checked, accepted);
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
+incdir+test
verilog/rv_isa_pkg.sv
verilog/dec_pipe_pkg.sv
verilog/dec_stage_if.sv
verilog/dec_imm_extract.sv
verilog/dec_field_capture.sv
verilog/dec_major_decode.sv
verilog/dec_op_select.sv
verilog/dec_top.sv
test/tb_dec_top.sv

/* Makefile */
# Verilator flow for the RV32I pipelined decoder

VERILATOR ?= verilator
TOP       ?= tb_dec_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
